// File: sources.f
design/ldpc_p3_pkg.sv
design/ldpc_hb_pkg.sv
design/ldpc_p3_ifs.sv
design/hb_row_sequencer.sv
design/circulant_mm_bank.sv
design/parity_combiner.sv
design/ldpc_enc_p3_top.sv
dv/ldpc_enc_p3_assertions.sv
dv/tb_ldpc_enc_p3.sv

// File: Makefile
# Verilator build of the parity stage testbench
# make compile | make run | make clean

VERILATOR ?= verilator
TOP       ?= tb_ldpc_enc_p3
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= -Wno-fatal
PASS_MSG  ?= All tests passed

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
	  --Mdir $(OBJ_DIR) -f $(FILELIST) $(VFLAGS)

# fails unless the pass message shows up in the output
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_ldpc_enc_p3.sv
//------------------------------
// testbench for the third parity stage
// xorshift lane data, p1 and acu, checked against a rotate-xor model
//------------------------------

module tb_ldpc_enc_p3;
  timeunit 1ns;
  timeprecision 100ps;

  import ldpc_p3_pkg::*;
  import ldpc_hb_pkg::*;

  localparam int TIMEOUT = 200;

  logic             iclk;
  logic             ireset;
  logic             iclkena;
  logic             iwrite;
  logic             iwstart;
  logic             istart;
  dat_t             iwdat0;
  dat_t             iwdat1;
  dat_t             iwdat2;
  dat_t             idat_p1;
  dat_t             idat_acu;
  logic             orow_req;
  logic [ROW_W-1:0] orow_idx;
  logic             obusy;
  logic             oval;
  logic             osop;
  logic             oeop;
  dat_t             odat;

  // model state
  logic [31:0]   rng;
  logic          rand_ena;
  dat_t          mem [N_LANES][N_COLS];
  int            wptr;
  // p1 and acu words keyed by enabled-cycle index
  dat_t          p1_at [int];
  dat_t          acu_at [int];
  // {sop, eop, word} per issued row
  logic [ZC+1:0] exp_q [$];
  int            ena_cnt;
  int            issued;
  int            beats;
  int            sops;
  int            eops;
  int            errors;
  int            tests_run;
  int            tests_failed;

  ldpc_enc_p3_top ldpc_enc_p3_top_inst (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .iwrite   (iwrite),
    .iwstart  (iwstart),
    .istart   (istart),
    .iwdat0   (iwdat0),
    .iwdat1   (iwdat1),
    .iwdat2   (iwdat2),
    .idat_p1  (idat_p1),
    .idat_acu (idat_acu),
    .orow_req (orow_req),
    .orow_idx (orow_idx),
    .obusy    (obusy),
    .oval     (oval),
    .osop     (osop),
    .oeop     (oeop),
    .odat     (odat)
  );

  initial begin
    iclk = 1'b0;
    forever #4 iclk = ~iclk;
  end

  //------------------------------
  // random source and model
  //------------------------------
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // out bit j of a lane = stored bit (j + shift) mod ZC, empty entry adds nothing
  function automatic dat_t row_product(int r);
    dat_t      acc;
    dat_t      w;
    hb_entry_t e;
    acc = '0;
    for (int l = 0; l < N_LANES; l++) begin
      e = HB_TABLE[r][l];
      w = mem[l][e.addr];
      if (e.valid) begin
        for (int j = 0; j < ZC; j++) begin
          acc[j] = acc[j] ^ w[(j + int'(e.shift)) % ZC];
        end
      end
    end
    return acc;
  endfunction

  // pop one expected row and compare
  task automatic check_beat();
    logic [ZC+1:0] exp;
    beats++;
    if (osop) begin
      sops++;
    end
    if (oeop) begin
      eops++;
    end
    if (exp_q.size() == 0) begin
      $display("output word at %0t arrived with no row outstanding", $time);
      errors++;
    end else begin
      exp = exp_q.pop_front();
      assert ({osop, oeop, odat} == exp) else begin
        $display("FAIL %0t: expected sop %b eop %b dat %h, got sop %b eop %b dat %h",
                 $time, exp[ZC+1], exp[ZC], exp[ZC-1:0], osop, oeop, odat);
        errors++;
      end
    end
  endtask

  //------------------------------
  // one clock cycle, inputs change on the falling edge
  //------------------------------
  task automatic run_cycle(input logic wr, input logic wst, input logic st);
    logic [31:0] r;
    dat_t        w [N_LANES];
    dat_t        p1;
    dat_t        acu;
    int          row;
    @(negedge iclk);
    // last edge was enabled, so a high oval is a new word
    if (iclkena && oval) begin
      check_beat();
    end
    r = next_rand();
    // writes and starts always land on an enabled edge
    iclkena = (wr || st || !rand_ena) ? 1'b1 : (r[1:0] != 2'b00);
    for (int l = 0; l < N_LANES; l++) begin
      w[l] = dat_t'(next_rand());
    end
    iwrite  = wr;
    iwstart = wst;
    istart  = st;
    iwdat0  = w[0];
    iwdat1  = w[1];
    iwdat2  = w[2];
    if (wr) begin
      if (wst) begin
        wptr = 0;
      end
      for (int l = 0; l < N_LANES; l++) begin
        mem[l][wptr] = w[l];
      end
      wptr = (wptr + 1) % N_COLS;
    end
    // responder, filler words where nothing is due
    idat_p1  = p1_at.exists(ena_cnt) ? p1_at[ena_cnt] : dat_t'(next_rand());
    idat_acu = acu_at.exists(ena_cnt) ? acu_at[ena_cnt] : dat_t'(next_rand());
    if (iclkena) begin
      p1_at.delete(ena_cnt);
      acu_at.delete(ena_cnt);
      if (orow_req) begin
        row = issued % N_ROWS;
        assert (int'(orow_idx) == row) else begin
          $display("FAIL %0t: row index %0d, expected %0d", $time, orow_idx, row);
          errors++;
        end
        p1  = dat_t'(next_rand());
        acu = dat_t'(next_rand());
        p1_at[ena_cnt + P1_LAT]   = p1;
        acu_at[ena_cnt + ACU_LAT] = acu;
        exp_q.push_back({row == 0, row == N_ROWS - 1, row_product(row) ^ p1 ^ acu});
        issued++;
      end
      ena_cnt++;
    end
  endtask

  // idle cycles until the sequencer is free, and optionally the queue is empty
  task automatic wait_for(input logic drain, input string what);
    int n;
    n = 0;
    // at least one edge, so a start driven just before has been taken
    do begin
      run_cycle(1'b0, 1'b0, 1'b0);
      n++;
    end while ((obusy || (drain && exp_q.size() != 0)) && n < TIMEOUT);
    if (obusy || (drain && exp_q.size() != 0)) begin
      $display("timeout: %s did not finish within %0d cycles", what, TIMEOUT);
      errors++;
    end
  endtask

  task automatic write_lanes();
    for (int c = 0; c < N_COLS; c++) begin
      run_cycle(1'b1, c == 0, 1'b0);
    end
  endtask

  function automatic int begin_test();
    beats = 0;
    sops  = 0;
    eops  = 0;
    return errors;
  endfunction

  task automatic finish_test(input string name, input int err0, input int want);
    assert (beats == want) else begin
      $display("FAIL %0t: %s gave %0d words, expected %0d", $time, name, beats, want);
      errors++;
    end
    tests_run++;
    if (errors != err0) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err0);
    end else begin
      $display("test %s: ok, %0d words", name, beats);
    end
  endtask

  //------------------------------
  // test sequence
  //------------------------------
  initial begin
    int err0;
    rng      = 32'h037f_aa01;
    rand_ena = 1'b0;
    ireset   = 1'b1;
    iclkena  = 1'b1;
    iwrite   = 1'b0;
    iwstart  = 1'b0;
    istart   = 1'b0;
    iwdat0   = '0;
    iwdat1   = '0;
    iwdat2   = '0;
    idat_p1  = '0;
    idat_acu = '0;
    wptr     = 0;
    ena_cnt  = 0;
    issued   = 0;
    errors   = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (3) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;

    // controls stay low without a start
    err0 = begin_test();
    for (int i = 0; i < 12; i++) begin
      run_cycle(1'b0, 1'b0, 1'b0);
      assert (!oval && !orow_req && !obusy) else begin
        $display("FAIL %0t: oval %b orow_req %b obusy %b, expected 0",
                 $time, oval, orow_req, obusy);
        errors++;
      end
    end
    finish_test("reset_idle", err0, 0);

    err0 = begin_test();
    write_lanes();
    run_cycle(1'b0, 1'b0, 1'b1);
    wait_for(1'b1, "single pass");
    finish_test("single_pass", err0, N_ROWS);

    // strobe positions are part of each expected word
    err0 = begin_test();
    run_cycle(1'b0, 1'b0, 1'b1);
    wait_for(1'b1, "strobe pass");
    assert (sops == 1 && eops == 1) else begin
      $display("FAIL %0t: %0d sop and %0d eop, expected 1 each", $time, sops, eops);
      errors++;
    end
    finish_test("strobes", err0, N_ROWS);

    // start pulses on rows 0, 2 and 4
    err0 = begin_test();
    run_cycle(1'b0, 1'b0, 1'b1);
    for (int i = 0; i < 5; i++) begin
      run_cycle(1'b0, 1'b0, i % 2 == 0);
    end
    wait_for(1'b1, "pass with extra starts");
    finish_test("start_while_busy", err0, N_ROWS);

    // rewrite and restart as soon as the sequencer frees up
    err0 = begin_test();
    for (int p = 0; p < 3; p++) begin
      wait_for(1'b0, "previous pass");
      write_lanes();
      run_cycle(1'b0, 1'b0, 1'b1);
    end
    wait_for(1'b1, "back-to-back passes");
    finish_test("back_to_back", err0, 3 * N_ROWS);

    err0 = begin_test();
    rand_ena = 1'b1;
    for (int p = 0; p < 2; p++) begin
      wait_for(1'b0, "previous gated pass");
      write_lanes();
      run_cycle(1'b0, 1'b0, 1'b1);
    end
    wait_for(1'b1, "gated passes");
    rand_ena = 1'b0;
    finish_test("clock_enable", err0, 2 * N_ROWS);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: dv/ldpc_enc_p3_assertions.sv
//------------------------------
// protocol checks on the parity stage top, attached with bind
//------------------------------

module ldpc_enc_p3_assertions (
  input logic                            iclk,
  input logic                            ireset,
  input logic                            iclkena,
  input logic                            istart,
  input logic                            orow_req,
  input logic [ldpc_p3_pkg::ROW_W-1:0]   orow_idx,
  input logic                            oval,
  input logic                            osop,
  input logic                            oeop,
  input ldpc_hb_pkg::seq_state_t         seq_state
);
  timeunit 1ns;
  timeprecision 100ps;

  import ldpc_p3_pkg::*;
  import ldpc_hb_pkg::*;

  // row requests delayed by enabled cycles only
  logic [OUT_LAT-1:0] req_dly;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      req_dly <= '0;
    end else if (iclkena) begin
      req_dly <= {req_dly[OUT_LAT-2:0], orow_req};
    end
  end

  // strobes only ride on an output word
  a_strb_beat: assert property (@(posedge iclk) disable iff (ireset)
    (osop || oeop) |-> oval)
    else $error("sop or eop without an output word");

  // a start taken in S_IDLE puts row 0 out on the next edge
  a_start_row0: assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && istart && seq_state == S_IDLE) |=> (orow_req && orow_idx == '0))
    else $error("start in S_IDLE did not issue row 0");

  // rows follow each other on enabled cycles without gaps
  a_row_step: assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && orow_req && orow_idx != ROW_W'(N_ROWS - 1))
      |=> (orow_req && orow_idx == $past(orow_idx) + 1'b1))
    else $error("row request skipped or ended before the last row");

  // output word exactly OUT_LAT enabled cycles after its request
  a_out_lat: assert property (@(posedge iclk) disable iff (ireset)
    oval == req_dly[OUT_LAT-1])
    else $error("oval does not follow orow_req by OUT_LAT enabled cycles");

endmodule

bind ldpc_enc_p3_top ldpc_enc_p3_assertions ldpc_enc_p3_assertions_inst (
  .iclk      (iclk),
  .ireset    (ireset),
  .iclkena   (iclkena),
  .istart    (istart),
  .orow_req  (orow_req),
  .orow_idx  (orow_idx),
  .oval      (oval),
  .osop      (osop),
  .oeop      (oeop),
  .seq_state (hb_row_sequencer_inst.state)
);

// File: design/ldpc_enc_p3_top.sv
//------------------------------
// third parity stage, sequencer + lane bank + combiner
// p1 and acu come from outside in answer to orow_req
//------------------------------

module ldpc_enc_p3_top (
  input  logic                          iclk,
  input  logic                          ireset,
  input  logic                          iclkena,
  input  logic                          iwrite,
  input  logic                          iwstart,
  input  logic                          istart,
  input  logic [ldpc_p3_pkg::ZC-1:0]    iwdat0,
  input  logic [ldpc_p3_pkg::ZC-1:0]    iwdat1,
  input  logic [ldpc_p3_pkg::ZC-1:0]    iwdat2,
  input  logic [ldpc_p3_pkg::ZC-1:0]    idat_p1,
  input  logic [ldpc_p3_pkg::ZC-1:0]    idat_acu,
  output logic                          orow_req,
  output logic [ldpc_p3_pkg::ROW_W-1:0] orow_idx,
  output logic                          obusy,
  output logic                          oval,
  output logic                          osop,
  output logic                          oeop,
  output logic [ldpc_p3_pkg::ZC-1:0]    odat
);
  import ldpc_p3_pkg::*;

  dat_t  iwdat [N_LANES];
  strb_t ostrb;

  mm_read_if mm_rd ();
  mm_out_if  mm_prod ();

  // lane order of the p2 write words
  assign iwdat[0] = iwdat0;
  assign iwdat[1] = iwdat1;
  assign iwdat[2] = iwdat2;

  hb_row_sequencer hb_row_sequencer_inst (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .istart   (istart),
    .rd       (mm_rd.mm_src),
    .orow_req (orow_req),
    .orow_idx (orow_idx),
    .obusy    (obusy)
  );

  circulant_mm_bank circulant_mm_bank_inst (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .iwrite  (iwrite),
    .iwstart (iwstart),
    .iwdat   (iwdat),
    .rd      (mm_rd.mm_sink),
    .prod    (mm_prod.prod_src)
  );

  parity_combiner parity_combiner_inst (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .prod     (mm_prod.prod_sink),
    .idat_p1  (idat_p1),
    .idat_acu (idat_acu),
    .oval     (oval),
    .ostrb    (ostrb),
    .odat     (odat)
  );

  assign osop = ostrb.sop;
  assign oeop = ostrb.eop;

endmodule

// File: design/parity_combiner.sv
//------------------------------
// adds p1 and acu onto the lane products
// two stages, one parity word per row with its strobes
//------------------------------

module parity_combiner (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               iclkena,
  mm_out_if.prod_sink        prod,
  input  ldpc_p3_pkg::dat_t  idat_p1,
  input  ldpc_p3_pkg::dat_t  idat_acu,
  output logic               oval,
  output ldpc_p3_pkg::strb_t ostrb,
  output ldpc_p3_pkg::dat_t  odat
);
  import ldpc_p3_pkg::*;

  logic [1:0] val_sr;
  strb_t      strb_q [2];
  dat_t       lane_sum;
  dat_t       sum_p1;

  // xor over all lanes
  always_comb begin
    lane_sum = '0;
    for (int l = 0; l < N_LANES; l++) begin
      lane_sum = lane_sum ^ prod.dat[l];
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_sr <= '0;
    end else if (iclkena) begin
      val_sr <= {val_sr[0], prod.val};
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      strb_q[0] <= prod.strb;
      strb_q[1] <= strb_q[0];
      // p1 arrives with the products
      sum_p1    <= lane_sum ^ idat_p1;
      // acu one cycle later
      odat      <= sum_p1 ^ idat_acu;
    end
  end

  assign oval  = val_sr[1];
  assign ostrb = strb_q[1];

endmodule

// File: design/circulant_mm_bank.sv
//------------------------------
// p2 lane RAMs with circulant rotators
// written in address order, read by row beats, two stages to the product
//------------------------------

module circulant_mm_bank (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              iclkena,
  input  logic              iwrite,
  input  logic              iwstart,
  input  ldpc_p3_pkg::dat_t iwdat [ldpc_p3_pkg::N_LANES],
  mm_read_if.mm_sink        rd,
  mm_out_if.prod_src        prod
);
  import ldpc_p3_pkg::*;

  addr_t wcnt;
  addr_t waddr;
  logic  val_q;
  strb_t strb_q;

  // out bit j takes stored bit (j + s) mod ZC
  function automatic dat_t rotr(dat_t w, shift_t s);
    logic [2*ZC-1:0] dw;
    dw = {w, w} >> s;
    return dw[ZC-1:0];
  endfunction

  //------------------------------
  // shared write address
  //------------------------------
  // iwstart restarts at column 0
  assign waddr = iwstart ? '0 : wcnt;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wcnt <= '0;
    end else if (iclkena && iwrite) begin
      wcnt <= waddr + 1'b1;
    end
  end

  //------------------------------
  // read control, two stages
  //------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_q    <= 1'b0;
      prod.val <= 1'b0;
    end else if (iclkena) begin
      val_q    <= rd.rval;
      prod.val <= val_q;
    end
  end

  // strobe delay, two stages alongside val
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      strb_q    <= rd.rstrb;
      prod.strb <= strb_q;
    end
  end

  //------------------------------
  // per-lane RAM and rotator
  //------------------------------
  for (genvar l = 0; l < N_LANES; l++) begin : g_lane
    dat_t   ram [N_COLS];
    dat_t   word_q;
    shift_t shift_q;
    logic   vld_q;
    dat_t   prod_q;

    always_ff @(posedge iclk) begin
      if (iclkena) begin
        if (iwrite) begin
          ram[waddr] <= iwdat[l];
        end
        // stage 1: raw word plus entry fields
        word_q  <= ram[rd.rhb[l].addr];
        shift_q <= rd.rhb[l].shift;
        vld_q   <= rd.rhb[l].valid;
        // stage 2: rotate, empty entries give zero
        prod_q  <= vld_q ? rotr(word_q, shift_q) : '0;
      end
    end

    assign prod.dat[l] = prod_q;
  end

endmodule

// File: design/hb_row_sequencer.sv
//------------------------------
// walks the base-matrix table once per start strobe
// one row per enabled cycle, no gaps, starts ignored while busy
//------------------------------

module hb_row_sequencer (
  input  logic                            iclk,
  input  logic                            ireset,
  input  logic                            iclkena,
  input  logic                            istart,
  mm_read_if.mm_src                       rd,
  output logic                            orow_req,
  output logic [ldpc_p3_pkg::ROW_W-1:0]   orow_idx,
  output logic                            obusy
);
  import ldpc_p3_pkg::*;
  import ldpc_hb_pkg::*;

  seq_state_t       state;
  logic [ROW_W-1:0] row;
  logic             last_row;

  assign last_row = (row == ROW_W'(N_ROWS - 1));

  //------------------------------
  // FSM and row counter
  //------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= S_IDLE;
      row   <= '0;
    end else if (iclkena) begin
      case (state)
        S_IDLE: begin
          // first row goes out on the next enabled cycle
          if (istart) begin
            state <= S_RUN;
            row   <= '0;
          end
        end
        S_RUN: begin
          if (last_row) begin
            state <= S_IDLE;
          end else begin
            row <= row + 1'b1;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  //------------------------------
  // read beat, one per row in S_RUN
  //------------------------------
  assign obusy    = (state == S_RUN);
  assign orow_req = obusy;
  assign orow_idx = row;

  assign rd.rval      = orow_req;
  // strobes only mark a live read beat
  assign rd.rstrb.sop = orow_req && (row == '0);
  assign rd.rstrb.eop = orow_req && last_row;

  // table lookup for all lanes of the current row
  always_comb begin
    for (int l = 0; l < N_LANES; l++) begin
      rd.rhb[l] = HB_TABLE[row][l];
    end
  end

endmodule

// File: design/ldpc_p3_ifs.sv
//------------------------------
// links inside the parity stage
// row reads go sequencer to lane bank, products go bank to combiner
//------------------------------

// one read beat per base-matrix row
interface mm_read_if;
  import ldpc_p3_pkg::*;
  import ldpc_hb_pkg::*;

  logic      rval;
  strb_t     rstrb;
  // entry for each lane of this row
  hb_entry_t rhb [N_LANES];

  modport mm_src  (output rval, output rstrb, output rhb);
  modport mm_sink (input rval, input rstrb, input rhb);

endinterface

// rotated lane words, aligned per row
interface mm_out_if;
  import ldpc_p3_pkg::*;

  logic  val;
  strb_t strb;
  dat_t  dat [N_LANES];

  modport prod_src  (output val, output strb, output dat);
  modport prod_sink (input val, input strb, input dat);

endinterface

// File: design/ldpc_hb_pkg.sv
//------------------------------
// base-matrix description for the row sequencer
// one entry per row and lane, plus the sequencer states
//------------------------------

package ldpc_hb_pkg;

  // one circulant of the base matrix
  typedef struct packed {
    logic                valid;
    ldpc_p3_pkg::addr_t  addr;
    ldpc_p3_pkg::shift_t shift;
  } hb_entry_t;

  // rows x lanes, fields are {valid, column, shift}
  // an invalid entry stands for an all-zero block
  localparam hb_entry_t HB_TABLE [ldpc_p3_pkg::N_ROWS][ldpc_p3_pkg::N_LANES] = '{
    // row 0
    '{'{1'b1, 2'd0, 3'd1}, '{1'b1, 2'd1, 3'd0}, '{1'b0, 2'd0, 3'd0}},
    // row 1
    '{'{1'b1, 2'd1, 3'd5}, '{1'b0, 2'd0, 3'd0}, '{1'b1, 2'd2, 3'd7}},
    // row 2
    '{'{1'b0, 2'd0, 3'd0}, '{1'b1, 2'd3, 3'd2}, '{1'b1, 2'd0, 3'd4}},
    // row 3, all three lanes
    '{'{1'b1, 2'd2, 3'd3}, '{1'b1, 2'd2, 3'd6}, '{1'b1, 2'd3, 3'd1}},
    // row 4, only lane 2
    '{'{1'b0, 2'd0, 3'd0}, '{1'b0, 2'd0, 3'd0}, '{1'b1, 2'd1, 3'd0}},
    // row 5
    '{'{1'b1, 2'd3, 3'd7}, '{1'b1, 2'd0, 3'd3}, '{1'b0, 2'd0, 3'd0}}
  };

  // sequencer FSM
  typedef enum logic {
    S_IDLE,
    S_RUN
  } seq_state_t;

endpackage

// File: design/ldpc_p3_pkg.sv
//------------------------------
// sizes, latencies and word types of the third parity stage
// imported by every block and by the testbench
//------------------------------

package ldpc_p3_pkg;

  // expansion factor, one word is ZC bits wide
  localparam int ZC      = 8;
  // p2 column groups, one lane each
  localparam int N_LANES = 3;
  // words kept per lane
  localparam int N_COLS  = 4;
  localparam int ADDR_W  = 2;
  // base-matrix rows walked per pass
  localparam int N_ROWS  = 6;
  localparam int ROW_W   = 3;

  typedef logic [ZC-1:0]     dat_t;
  typedef logic [ADDR_W-1:0] addr_t;
  // rotate amount, 0 .. ZC-1
  typedef logic [2:0]        shift_t;

  typedef struct packed {
    logic sop;
    logic eop;
  } strb_t;

  // latencies in enabled cycles
  localparam int MM_LAT  = 2;
  localparam int P1_LAT  = 2;
  localparam int ACU_LAT = 3;
  // row request to output word
  localparam int OUT_LAT = 4;

endpackage
